//--- Bender.yml
package:
  name: periph

sources:
  # RTL, package first
  - hdl/periph_pkg.sv
  - hdl/axil_decode.sv
  - hdl/uart_tx_engine.sv
  - hdl/axil_response.sv
  - hdl/periph_top.sv
  # Testbench
  - target: test
    files:
      - dv/uart_monitor.sv
      - dv/periph_tb.sv

//--- dv/periph_tb.sv
`timescale 1ns/10ps

module periph_tb;
	import periph_pkg::*;

	localparam int CLKS_PER_BIT = 8;
	localparam int GPIO_W       = 8;
	// Test lengths
	localparam int N_GPIO    = 8;
	localparam int N_GPIO_IN = 4;
	localparam int N_BYTES   = 40;
	localparam int N_STATUS  = 2;
	localparam int N_ERR     = 6;
	localparam int N_BP      = 6;
	// Every bus access over the whole run
	localparam int N_XACT = 1 + 2 * N_GPIO + N_GPIO_IN + N_BYTES + N_STATUS + N_ERR + 2 * N_BP;
	localparam int TIMEOUT_CYCLES = (N_BYTES * 10 * CLKS_PER_BIT + 40 * N_XACT) * 2;

	logic                   clk = 1'b0;
	logic                   rst_n;
	// AXI4-Lite master side
	logic                   awvalid;
	logic                   awready;
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic                   wvalid;
	logic                   wready;
	logic [AXIL_DATA_W-1:0] wdata;
	logic [3:0]             wstrb;
	logic                   bvalid;
	logic                   bready;
	logic [1:0]             bresp;
	logic                   arvalid;
	logic                   arready;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic                   rvalid;
	logic                   rready;
	logic [AXIL_DATA_W-1:0] rdata;
	logic [1:0]             rresp;
	// Pins and monitor
	logic [GPIO_W-1:0]      gpio_in;
	logic [GPIO_W-1:0]      gpio_out;
	logic                   uart_tx;
	logic                   rx_valid;
	logic                   frame_err;
	logic [7:0]             rx_byte;
	// Reference model
	logic [7:0]             exp_bytes[$];
	logic [GPIO_W-1:0]      gpio_shadow;
	logic [GPIO_W-1:0]      gpio_pins;
	logic                   pend_q = 1'b0;
	int                     cycle_cnt = 0;

	always #2 clk = ~clk;

	periph_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.GPIO_W       (GPIO_W)
	) periph_top_inst (
		.clk_i     (clk),
		.rst_n_i   (rst_n),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.awaddr_i  (awaddr),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.bvalid_o  (bvalid),
		.bready_i  (bready),
		.bresp_o   (bresp),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.araddr_i  (araddr),
		.rvalid_o  (rvalid),
		.rready_i  (rready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.gpio_i    (gpio_in),
		.gpio_o    (gpio_out),
		.uart_tx_o (uart_tx)
	);

	uart_monitor #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) monitor_inst (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.rx_i        (uart_tx),
		.rx_valid_o  (rx_valid),
		.rx_byte_o   (rx_byte),
		.frame_err_o (frame_err)
	);

	//////////////////////////////////////////////////
	// Checking helpers
	//////////////////////////////////////////////////

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Offsets outside the four registers
	function automatic logic [AXIL_ADDR_W-1:0] unmapped_addr();
		logic [AXIL_ADDR_W-1:0] a;
		do a = AXIL_ADDR_W'($urandom_range(0, 15));
		while (a == ADDR_TXDATA || a == ADDR_STATUS || a == ADDR_GPIO_OUT || a == ADDR_GPIO_IN);
		return a;
	endfunction

	//////////////////////////////////////////////////
	// AXI4-Lite master tasks
	//////////////////////////////////////////////////

	// AW and W together, then B held off for b_hold cycles
	task automatic write_reg(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
			input int b_hold, output logic [1:0] resp);
		repeat ($urandom_range(1, 3)) @(posedge clk);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		// Strobes are ignored by the slave
		wstrb   <= 4'($urandom_range(0, 15));
		do @(negedge clk); while (!awready);
		check_val("wready_o", wready, 1'b1);
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		// B follows one cycle after the handshake
		@(negedge clk);
		check_val("bvalid_o", bvalid, 1'b1);
		repeat (b_hold) begin
			@(negedge clk);
			check_val("bvalid_o", bvalid, 1'b1);
		end
		@(posedge clk);
		bready <= 1'b1;
		@(negedge clk);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [AXIL_ADDR_W-1:0] addr, input int r_hold,
			output logic [31:0] data, output logic [1:0] resp);
		repeat ($urandom_range(1, 3)) @(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		check_val("rvalid_o", rvalid, 1'b1);
		repeat (r_hold) begin
			@(negedge clk);
			check_val("rvalid_o", rvalid, 1'b1);
		end
		@(posedge clk);
		rready <= 1'b1;
		@(negedge clk);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Background checks
	//////////////////////////////////////////////////

	// No ready may follow a cycle with a response pending
	always @(negedge clk) begin
		if (rst_n) begin
			assert (!((awready || arready) && pend_q)) else begin
				$display("Handshake accepted at %0t while a response was pending", $time);
				abort_run();
			end
		end
		pend_q = bvalid || rvalid;
	end

	// UART bytes in write order
	always @(negedge clk) begin
		assert (!frame_err) else begin
			$display("UART monitor saw a broken frame at %0t", $time);
			abort_run();
		end
		if (rx_valid) begin
			assert (exp_bytes.size() > 0) else begin
				$display("UART byte 0x%0h arrived with none expected", rx_byte);
				abort_run();
			end
			check_val("uart_tx_o byte", rx_byte, exp_bytes.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [1:0]             resp;
		logic [1:0]             bp_resp;
		logic [31:0]            data;
		logic [31:0]            wd;
		logic [AXIL_ADDR_W-1:0] addr;
		logic [GPIO_W-1:0]      rd_exp;
		void'($urandom(32'h194d_d9fe));
		rst_n   <= 1'b0;
		awvalid <= 1'b0;
		awaddr  <= '0;
		wvalid  <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		bready  <= 1'b0;
		arvalid <= 1'b0;
		araddr  <= '0;
		rready  <= 1'b0;
		gpio_in <= '0;
		gpio_shadow = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// Idle state out of reset
		@(negedge clk);
		check_val("uart_tx_o", uart_tx, 1'b1);
		check_val("gpio_o", gpio_out, '0);
		check_val("ready outputs", {awready, wready, arready}, '0);
		check_val("valid outputs", {bvalid, rvalid}, '0);
		read_reg(ADDR_STATUS, 0, data, resp);
		check_val("rdata_o", data, '0);
		check_val("rresp_o", resp, RESP_OKAY);

		// GPIO output register
		for (int i = 0; i < N_GPIO; i++) begin
			wd = $urandom;
			write_reg(ADDR_GPIO_OUT, wd, $urandom_range(0, 2), resp);
			check_val("bresp_o", resp, RESP_OKAY);
			gpio_shadow = wd[GPIO_W-1:0];
			check_val("gpio_o", gpio_out, gpio_shadow);
			read_reg(ADDR_GPIO_OUT, $urandom_range(0, 2), data, resp);
			check_val("rdata_o", data, 32'(gpio_shadow));
			check_val("rresp_o", resp, RESP_OKAY);
		end

		// GPIO input through the synchronizer
		for (int i = 0; i < N_GPIO_IN; i++) begin
			gpio_pins = GPIO_W'($urandom);
			@(posedge clk);
			gpio_in <= gpio_pins;
			repeat (3) @(posedge clk);
			read_reg(ADDR_GPIO_IN, 0, data, resp);
			check_val("rdata_o", data, 32'(gpio_pins));
			check_val("rresp_o", resp, RESP_OKAY);
		end

		// Back to back bytes
		// Writes stall on a full holding register
		for (int i = 0; i < N_BYTES; i++) begin
			wd = $urandom;
			exp_bytes.push_back(wd[7:0]);
			write_reg(ADDR_TXDATA, wd, 0, resp);
			check_val("bresp_o", resp, RESP_OKAY);
			// First byte goes straight to the shifter
			// The second one waits in the holding register
			if (i < N_STATUS) begin
				read_reg(ADDR_STATUS, 0, data, resp);
				check_val("rdata_o", data, (i == 0) ? 32'h1 : 32'h3);
				check_val("rresp_o", resp, RESP_OKAY);
			end
		end
		while (exp_bytes.size() != 0) @(negedge clk);

		// Read-only and unmapped offsets
		write_reg(ADDR_STATUS, $urandom, 0, resp);
		check_val("bresp_o", resp, RESP_SLVERR);
		write_reg(ADDR_GPIO_IN, $urandom, 0, resp);
		check_val("bresp_o", resp, RESP_SLVERR);
		for (int i = 0; i < (N_ERR - 2) / 2; i++) begin
			write_reg(unmapped_addr(), $urandom, 0, resp);
			check_val("bresp_o", resp, RESP_SLVERR);
			addr = unmapped_addr();
			read_reg(addr, 0, data, resp);
			check_val("rdata_o", data, '0);
			check_val("rresp_o", resp, RESP_SLVERR);
		end
		check_val("gpio_o", gpio_out, gpio_shadow);
		check_val("uart_tx_o", uart_tx, 1'b1);

		// Second access queued behind a held-off response
		for (int i = 0; i < N_BP; i++) begin
			wd = $urandom;
			if (i % 2 == 0) begin
				// Read waits for the B of a write
				fork
					begin
						write_reg(ADDR_GPIO_OUT, wd, $urandom_range(2, 10), bp_resp);
					end
					begin
						do @(negedge clk); while (!awready);
						read_reg(ADDR_GPIO_OUT, $urandom_range(2, 10), data, resp);
					end
				join
				gpio_shadow = wd[GPIO_W-1:0];
				rd_exp      = gpio_shadow;
			end else begin
				// Write waits for the R of a read
				fork
					begin
						read_reg(ADDR_GPIO_OUT, $urandom_range(2, 10), data, resp);
					end
					begin
						do @(negedge clk); while (!arready);
						write_reg(ADDR_GPIO_OUT, wd, $urandom_range(2, 10), bp_resp);
					end
				join
				rd_exp      = gpio_shadow;
				gpio_shadow = wd[GPIO_W-1:0];
			end
			check_val("bresp_o", bp_resp, RESP_OKAY);
			check_val("rdata_o", data, 32'(rd_exp));
			check_val("rresp_o", resp, RESP_OKAY);
			check_val("gpio_o", gpio_out, gpio_shadow);
		end

		repeat (4) @(posedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

//--- dv/uart_monitor.sv
`timescale 1ns/10ps

module uart_monitor #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk_i,
	input  logic       rst_n_i,
	// Serial line from the DUT
	input  logic       rx_i,
	// One-cycle pulse per received byte
	output logic       rx_valid_o,
	output logic [7:0] rx_byte_o,
	// Sticky flag for a bad start or stop bit
	output logic       frame_err_o
);

	// Line sampled on falling edges between DUT updates
	initial begin
		logic [7:0] shift;
		logic       start_bit;
		logic       stop_bit;
		int         bit_idx;
		rx_valid_o  = 1'b0;
		rx_byte_o   = '0;
		frame_err_o = 1'b0;
		forever begin
			// Hunt for the start bit edge
			do @(negedge clk_i); while (!(rst_n_i && rx_i === 1'b0));
			// Move to the middle of the start bit
			repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk_i);
			start_bit = rx_i;
			// Eight data bits, LSB first
			for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
				repeat (CLKS_PER_BIT) @(negedge clk_i);
				shift[bit_idx] = rx_i;
			end
			repeat (CLKS_PER_BIT) @(negedge clk_i);
			stop_bit = rx_i;
			// Hand the byte over on a rising edge
			@(posedge clk_i);
			if (start_bit !== 1'b0 || stop_bit !== 1'b1) begin
				frame_err_o <= 1'b1;
			end else begin
				rx_valid_o <= 1'b1;
				rx_byte_o  <= shift;
			end
			@(posedge clk_i);
			rx_valid_o <= 1'b0;
		end
	end

endmodule

//--- flist.f
hdl/periph_pkg.sv
hdl/axil_decode.sv
hdl/uart_tx_engine.sv
hdl/axil_response.sv
hdl/periph_top.sv
dv/uart_monitor.sv
dv/periph_tb.sv

//--- hdl/axil_decode.sv
`timescale 1ns/10ps

module axil_decode (
	input  logic                               clk_i,
	input  logic                               rst_n_i,
	// Write address and data channels
	input  logic                               awvalid_i,
	output logic                               awready_o,
	input  logic [periph_pkg::AXIL_ADDR_W-1:0] awaddr_i,
	input  logic                               wvalid_i,
	output logic                               wready_o,
	input  logic [periph_pkg::AXIL_DATA_W-1:0] wdata_i,
	input  logic [3:0]                         wstrb_i,
	// Read address channel
	input  logic                               arvalid_i,
	output logic                               arready_o,
	input  logic [periph_pkg::AXIL_ADDR_W-1:0] araddr_i,
	// From response block and UART engine
	input  logic                               resp_busy_i,
	input  logic                               tx_hold_full_i,
	// Requests to response block
	output logic                               wr_req_o,
	output periph_pkg::reg_sel_e               wr_sel_o,
	output logic [periph_pkg::AXIL_DATA_W-1:0] wr_data_o,
	output logic                               rd_req_o,
	output periph_pkg::reg_sel_e               rd_sel_o,
	// Byte load into UART engine
	output logic                               tx_load_o,
	output logic [7:0]                         tx_byte_o
);
	import periph_pkg::*;

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	// Exact offset match only
	// Any other offset decodes to SEL_NONE
	function automatic reg_sel_e addr_to_sel(input logic [AXIL_ADDR_W-1:0] addr);
		reg_sel_e sel;
		case (addr)
			ADDR_TXDATA:   sel = SEL_TXDATA;
			ADDR_STATUS:   sel = SEL_STATUS;
			ADDR_GPIO_OUT: sel = SEL_GPIO_OUT;
			ADDR_GPIO_IN:  sel = SEL_GPIO_IN;
			default:       sel = SEL_NONE;
		endcase
		return sel;
	endfunction

	reg_sel_e               aw_sel;
	reg_sel_e               ar_sel;
	logic                   hs_cycle;
	logic                   tx_stall;
	logic                   wr_accept;
	logic                   rd_accept;
	// Ready and request pulse share one handshake flop
	logic                   wr_hs_q;
	logic                   rd_hs_q;
	logic                   tx_load_q;
	// Captured request payload
	reg_sel_e               wr_sel_q;
	reg_sel_e               rd_sel_q;
	logic [AXIL_DATA_W-1:0] wr_data_q;
	logic [7:0]             tx_byte_q;

	//////////////////////////////////////////////////
	// Accept rules
	//////////////////////////////////////////////////

	assign aw_sel = addr_to_sel(awaddr_i);
	assign ar_sel = addr_to_sel(araddr_i);

	// No second issue while a ready is up
	assign hs_cycle = wr_hs_q | rd_hs_q;

	// Holding register full blocks TXDATA writes only
	assign tx_stall = (aw_sel == SEL_TXDATA) & tx_hold_full_i;

	// Needs both AW and W valid
	// Strobes play no part here
	assign wr_accept = awvalid_i & wvalid_i & ~tx_stall & ~resp_busy_i & ~hs_cycle;

	// Write wins a tie
	// a stalled write lets a read through
	assign rd_accept = arvalid_i & ~wr_accept & ~resp_busy_i & ~hs_cycle;

	//////////////////////////////////////////////////
	// Handshake and request registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_hs_q   <= 1'b0;
			rd_hs_q   <= 1'b0;
			tx_load_q <= 1'b0;
		end else begin
			wr_hs_q   <= wr_accept;
			rd_hs_q   <= rd_accept;
			// Load the UART only on accepted TXDATA writes
			tx_load_q <= wr_accept & (aw_sel == SEL_TXDATA);
		end
	end

	// Master holds data stable until ready
	// Sampling on the accept cycle is safe
	always_ff @(posedge clk_i) begin
		if (wr_accept) begin
			wr_sel_q  <= aw_sel;
			wr_data_q <= wdata_i;
			tx_byte_q <= wdata_i[7:0];
		end
		if (rd_accept) begin
			rd_sel_q <= ar_sel;
		end
	end

	// AW and W accepted together
	assign awready_o = wr_hs_q;
	assign wready_o  = wr_hs_q;
	assign arready_o = rd_hs_q;
	assign wr_req_o  = wr_hs_q;
	assign wr_sel_o  = wr_sel_q;
	assign wr_data_o = wr_data_q;
	assign rd_req_o  = rd_hs_q;
	assign rd_sel_o  = rd_sel_q;
	assign tx_load_o = tx_load_q;
	assign tx_byte_o = tx_byte_q;

endmodule

//--- hdl/axil_response.sv
`timescale 1ns/10ps

module axil_response #(
	parameter int GPIO_W = 8
) (
	input  logic                               clk_i,
	input  logic                               rst_n_i,
	// Requests from decode
	input  logic                               wr_req_i,
	input  periph_pkg::reg_sel_e               wr_sel_i,
	input  logic [periph_pkg::AXIL_DATA_W-1:0] wr_data_i,
	input  logic                               rd_req_i,
	input  periph_pkg::reg_sel_e               rd_sel_i,
	// B and R channels
	input  logic                               bready_i,
	output logic                               bvalid_o,
	output logic [1:0]                         bresp_o,
	input  logic                               rready_i,
	output logic                               rvalid_o,
	output logic [1:0]                         rresp_o,
	output logic [periph_pkg::AXIL_DATA_W-1:0] rdata_o,
	// Pins and UART status
	input  logic [GPIO_W-1:0]                  gpio_i,
	output logic [GPIO_W-1:0]                  gpio_o,
	input  logic                               tx_busy_i,
	input  logic                               tx_hold_full_i,
	// Holds off decode while a response waits
	output logic                               resp_busy_o
);
	import periph_pkg::*;

	logic [GPIO_W-1:0]      gpio_out_q;
	logic [GPIO_W-1:0]      gpio_meta_q;
	logic [GPIO_W-1:0]      gpio_sync_q;
	logic                   bvalid_q;
	logic                   rvalid_q;
	logic [1:0]             bresp_q;
	logic [1:0]             rresp_q;
	logic [AXIL_DATA_W-1:0] rdata_q;
	logic [AXIL_DATA_W-1:0] rd_mux;
	logic                   wr_ok;
	logic                   rd_ok;

	// Only TXDATA and GPIO_OUT are writable
	assign wr_ok = (wr_sel_i == SEL_TXDATA) | (wr_sel_i == SEL_GPIO_OUT);
	assign rd_ok = (rd_sel_i != SEL_NONE);

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	// TXDATA and unmapped offsets read as zero
	always_comb begin
		rd_mux = '0;
		case (rd_sel_i)
			SEL_STATUS: begin
				rd_mux[0] = tx_busy_i;
				rd_mux[1] = tx_hold_full_i;
			end
			SEL_GPIO_OUT: rd_mux[GPIO_W-1:0] = gpio_out_q;
			SEL_GPIO_IN:  rd_mux[GPIO_W-1:0] = gpio_sync_q;
			default:      rd_mux = '0;
		endcase
	end

	// Valids stay up until the master takes them
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bvalid_q   <= 1'b0;
			rvalid_q   <= 1'b0;
			gpio_out_q <= '0;
		end else begin
			if (wr_req_i) begin
				bvalid_q <= 1'b1;
			end else if (bready_i) begin
				bvalid_q <= 1'b0;
			end
			if (rd_req_i) begin
				rvalid_q <= 1'b1;
			end else if (rready_i) begin
				rvalid_q <= 1'b0;
			end
			if (wr_req_i && wr_sel_i == SEL_GPIO_OUT) begin
				gpio_out_q <= wr_data_i[GPIO_W-1:0];
			end
		end
	end

	// Response payload and 2-flop pin synchronizer
	always_ff @(posedge clk_i) begin
		if (wr_req_i) begin
			bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_req_i) begin
			rdata_q <= rd_mux;
			rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
		gpio_meta_q <= gpio_i;
		gpio_sync_q <= gpio_meta_q;
	end

	assign bvalid_o    = bvalid_q;
	assign bresp_o     = bresp_q;
	assign rvalid_o    = rvalid_q;
	assign rresp_o     = rresp_q;
	assign rdata_o     = rdata_q;
	assign gpio_o      = gpio_out_q;
	assign resp_busy_o = bvalid_q | rvalid_q;

endmodule

//--- hdl/periph_pkg.sv
package periph_pkg;

	//////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////

	// Byte offset into the four-register window
	localparam int AXIL_ADDR_W = 4;
	// AXI4-Lite data width
	localparam int AXIL_DATA_W = 32;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	// Write-only UART transmit byte
	localparam logic [AXIL_ADDR_W-1:0] ADDR_TXDATA   = 4'h0;
	// Bit 0 tx_busy, bit 1 tx_hold_full
	localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS   = 4'h4;
	localparam logic [AXIL_ADDR_W-1:0] ADDR_GPIO_OUT = 4'h8;
	// Read-only synchronized pin state
	localparam logic [AXIL_ADDR_W-1:0] ADDR_GPIO_IN  = 4'hC;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Decoded target of an access
	typedef enum logic [2:0] {
		SEL_TXDATA,
		SEL_STATUS,
		SEL_GPIO_OUT,
		SEL_GPIO_IN,
		SEL_NONE
	} reg_sel_e;

	// 8N1 transmit FSM
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

//--- hdl/periph_top.sv
`timescale 1ns/10ps

module periph_top #(
	parameter int CLKS_PER_BIT = 8,
	parameter int GPIO_W       = 8
) (
	input  logic                               clk_i,
	input  logic                               rst_n_i,
	// AXI4-Lite slave
	input  logic                               awvalid_i,
	output logic                               awready_o,
	input  logic [periph_pkg::AXIL_ADDR_W-1:0] awaddr_i,
	input  logic                               wvalid_i,
	output logic                               wready_o,
	input  logic [periph_pkg::AXIL_DATA_W-1:0] wdata_i,
	input  logic [3:0]                         wstrb_i,
	output logic                               bvalid_o,
	input  logic                               bready_i,
	output logic [1:0]                         bresp_o,
	input  logic                               arvalid_i,
	output logic                               arready_o,
	input  logic [periph_pkg::AXIL_ADDR_W-1:0] araddr_i,
	output logic                               rvalid_o,
	input  logic                               rready_i,
	output logic [periph_pkg::AXIL_DATA_W-1:0] rdata_o,
	output logic [1:0]                         rresp_o,
	// Pins
	input  logic [GPIO_W-1:0]                  gpio_i,
	output logic [GPIO_W-1:0]                  gpio_o,
	output logic                               uart_tx_o
);
	import periph_pkg::*;

	//////////////////////////////////////////////////
	// Internal links
	//////////////////////////////////////////////////

	// Decode to response
	logic                   wr_req;
	reg_sel_e               wr_sel;
	logic [AXIL_DATA_W-1:0] wr_data;
	logic                   rd_req;
	reg_sel_e               rd_sel;
	logic                   resp_busy;
	// Decode to UART engine
	logic                   tx_load;
	logic [7:0]             tx_byte;
	// UART engine status
	logic                   tx_hold_full;
	logic                   tx_busy;

	axil_decode decode_inst (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.awvalid_i      (awvalid_i),
		.awready_o      (awready_o),
		.awaddr_i       (awaddr_i),
		.wvalid_i       (wvalid_i),
		.wready_o       (wready_o),
		.wdata_i        (wdata_i),
		.wstrb_i        (wstrb_i),
		.arvalid_i      (arvalid_i),
		.arready_o      (arready_o),
		.araddr_i       (araddr_i),
		.resp_busy_i    (resp_busy),
		.tx_hold_full_i (tx_hold_full),
		.wr_req_o       (wr_req),
		.wr_sel_o       (wr_sel),
		.wr_data_o      (wr_data),
		.rd_req_o       (rd_req),
		.rd_sel_o       (rd_sel),
		.tx_load_o      (tx_load),
		.tx_byte_o      (tx_byte)
	);

	uart_tx_engine #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) tx_engine_inst (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.tx_load_i      (tx_load),
		.tx_byte_i      (tx_byte),
		.tx_hold_full_o (tx_hold_full),
		.tx_busy_o      (tx_busy),
		.uart_tx_o      (uart_tx_o)
	);

	axil_response #(
		.GPIO_W (GPIO_W)
	) response_inst (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.wr_req_i       (wr_req),
		.wr_sel_i       (wr_sel),
		.wr_data_i      (wr_data),
		.rd_req_i       (rd_req),
		.rd_sel_i       (rd_sel),
		.bready_i       (bready_i),
		.bvalid_o       (bvalid_o),
		.bresp_o        (bresp_o),
		.rready_i       (rready_i),
		.rvalid_o       (rvalid_o),
		.rresp_o        (rresp_o),
		.rdata_o        (rdata_o),
		.gpio_i         (gpio_i),
		.gpio_o         (gpio_o),
		.tx_busy_i      (tx_busy),
		.tx_hold_full_i (tx_hold_full),
		.resp_busy_o    (resp_busy)
	);

endmodule

//--- hdl/uart_tx_engine.sv
`timescale 1ns/10ps

module uart_tx_engine #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk_i,
	input  logic       rst_n_i,
	// Byte from the bus side
	input  logic       tx_load_i,
	input  logic [7:0] tx_byte_i,
	// Status back to the bus side
	output logic       tx_hold_full_o,
	output logic       tx_busy_o,
	// Serial line idles high
	output logic       uart_tx_o
);
	import periph_pkg::*;

	// Counter wide enough for one bit period
	localparam int               CNT_W    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	tx_state_e        state_q;
	logic [CNT_W-1:0] baud_cnt_q;
	logic [2:0]       bit_idx_q;
	logic             hold_full_q;
	logic [7:0]       hold_data_q;
	logic [7:0]       shift_q;
	logic             tx_q;
	logic             bit_done;
	logic             start_frame;

	// Last cycle of the current bit
	assign bit_done = (baud_cnt_q == CNT_LAST);

	// Idle shifter picks up the waiting byte
	assign start_frame = (state_q == TX_IDLE) & hold_full_q;

	//////////////////////////////////////////////////
	// Holding register
	//////////////////////////////////////////////////

	// Decode never loads while full
	// so load and pickup do not collide
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			hold_full_q <= 1'b0;
		end else if (tx_load_i) begin
			hold_full_q <= 1'b1;
		end else if (start_frame) begin
			hold_full_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (tx_load_i) begin
			hold_data_q <= tx_byte_i;
		end
		// Shift out LSB first
		if (start_frame) begin
			shift_q <= hold_data_q;
		end else if (state_q == TX_DATA && bit_done) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	// Line level is registered with the state
	// so each bit lasts exactly CLKS_PER_BIT cycles
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q    <= TX_IDLE;
			baud_cnt_q <= '0;
			bit_idx_q  <= '0;
			tx_q       <= 1'b1;
		end else begin
			// Baud counter restarts every bit
			if (state_q == TX_IDLE || bit_done) begin
				baud_cnt_q <= '0;
			end else begin
				baud_cnt_q <= baud_cnt_q + 1'b1;
			end
			case (state_q)
				TX_IDLE: begin
					if (hold_full_q) begin
						state_q <= TX_START;
						tx_q    <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_done) begin
						state_q   <= TX_DATA;
						bit_idx_q <= '0;
						tx_q      <= shift_q[0];
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						if (bit_idx_q == 3'd7) begin
							state_q <= TX_STOP;
							tx_q    <= 1'b1;
						end else begin
							bit_idx_q <= bit_idx_q + 1'b1;
							// Next bit after the shift
							tx_q      <= shift_q[1];
						end
					end
				end
				TX_STOP: begin
					// One idle cycle before any next start bit
					if (bit_done) begin
						state_q <= TX_IDLE;
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	assign tx_hold_full_o = hold_full_q;
	assign tx_busy_o      = (state_q != TX_IDLE);
	assign uart_tx_o      = tx_q;

endmodule
